// ==== axil_pkg.sv ====
package axil_pkg;

    typedef logic [7:0]  axil_addr_t;
    typedef logic [31:0] axil_data_t;
    typedef logic [1:0]  axil_resp_t;

    // Response codes.
    localparam axil_resp_t resp_okay   = 2'd0;
    localparam axil_resp_t resp_slverr = 2'd2;

    // Register map.
    localparam axil_addr_t reg_status    = 8'h00; // Full, empty, sticky oflow, sticky uflow.
    localparam axil_addr_t reg_wr_count  = 8'h04; // Write side fill count.
    localparam axil_addr_t reg_rd_count  = 8'h08; // Read side fill count.
    localparam axil_addr_t reg_oflow_cnt = 8'h0C; // Saturating overflow events.
    localparam axil_addr_t reg_uflow_cnt = 8'h10; // Saturating underflow events.
    localparam axil_addr_t reg_depth     = 8'h14; // FIFO depth.
    localparam axil_addr_t reg_control   = 8'h18; // Write only.

    // Bit positions inside reg_control.
    localparam int ctrl_clear_bit = 0;
    localparam int ctrl_flush_bit = 1;

    // Host to slave.
    typedef struct packed {
        axil_addr_t awaddr;
        logic       awvalid;
        axil_data_t wdata;
        logic [3:0] wstrb;
        logic       wvalid;
        logic       bready;
        axil_addr_t araddr;
        logic       arvalid;
        logic       rready;
    } axil_req_t;

    // Slave to host.
    typedef struct packed {
        logic       awready;
        logic       wready;
        axil_resp_t bresp;
        logic       bvalid;
        logic       arready;
        axil_data_t rdata;
        axil_resp_t rresp;
        logic       rvalid;
    } axil_rsp_t;

endpackage

// ==== fifo_axil.f ====
axil_pkg.sv
fifo_pkg.sv
fifo_core.sv
fifo_axil_regs.sv
fifo_axil.sv
fifo_axil_tb.sv

// ==== fifo_axil.sv ====
module fifo_axil import axil_pkg::*, fifo_pkg::*; #(
    parameter int  DEPTH      = 16,
    parameter bit  FWFT       = 1,
    parameter bit  OFLOW_PROT = 1,
    parameter bit  UFLOW_PROT = 1,
    localparam int CNT_WID    = FWFT ? $clog2(DEPTH + 2) : $clog2(DEPTH + 1)
) (
    input  logic               rd_clk,
    input  logic               rd_srst,

    output logic               wr_rdy,
    input  logic               wr,
    input  data_t              wr_data,

    input  logic               rd,
    output logic               rd_ack,
    output data_t              rd_data,

    output logic [CNT_WID-1:0] wr_count,
    output logic [CNT_WID-1:0] rd_count,
    output logic               full,
    output logic               empty,
    output logic               oflow,
    output logic               uflow,

    input  axil_req_t          axil_req,
    output axil_rsp_t          axil_rsp
);

    fifo_status_t       status;
    logic [CNT_WID-1:0] core_rd_count;
    logic               flush;

    fifo_core #(
        .DEPTH      (DEPTH),
        .FWFT       (FWFT),
        .OFLOW_PROT (OFLOW_PROT),
        .UFLOW_PROT (UFLOW_PROT)
    ) fifo_core_inst (
        .rd_clk   (rd_clk),
        .rd_srst  (rd_srst),
        .wr_rdy   (wr_rdy),
        .wr       (wr),
        .wr_data  (wr_data),
        .rd       (rd),
        .flush    (flush),
        .rd_ack   (rd_ack),
        .rd_data  (rd_data),
        .wr_count (wr_count),
        .rd_count (core_rd_count),
        .status   (status)
    );

    fifo_axil_regs #(
        .DEPTH (DEPTH),
        .FWFT  (FWFT)
    ) fifo_axil_regs_inst (
        .rd_clk   (rd_clk),
        .rd_srst  (rd_srst),
        .axil_req (axil_req),
        .axil_rsp (axil_rsp),
        .status   (status),
        .wr_count (wr_count),
        .rd_count (core_rd_count),
        .flush    (flush)
    );

    assign full  = status.full;
    assign empty = status.empty;
    assign oflow = status.oflow;
    assign uflow = status.uflow;

    always_ff @(posedge rd_clk) begin
        if (rd_srst) begin
            rd_count <= '0;
        end else begin
            rd_count <= core_rd_count; // One extra cycle of lag.
        end
    end

endmodule

// ==== fifo_axil_regs.sv ====
module fifo_axil_regs import axil_pkg::*, fifo_pkg::*; #(
    parameter int  DEPTH   = 16,
    parameter bit  FWFT    = 1,
    localparam int CNT_WID = FWFT ? $clog2(DEPTH + 2) : $clog2(DEPTH + 1)
) (
    input  logic               rd_clk,
    input  logic               rd_srst,

    input  axil_req_t          axil_req,
    output axil_rsp_t          axil_rsp,

    input  fifo_status_t       status,
    input  logic [CNT_WID-1:0] wr_count,
    input  logic [CNT_WID-1:0] rd_count,
    output logic               flush
);

    logic             wr_take;
    logic             rd_take;
    logic             wr_mapped;
    logic             ctrl_hit;
    logic             clear_req;
    axil_data_t       rd_word;
    axil_resp_t       rd_resp;

    logic             bvalid_q;
    axil_resp_t       bresp_q;
    logic             rvalid_q;
    axil_data_t       rdata_q;
    axil_resp_t       rresp_q;
    logic             flush_q;

    logic [1:0]       err_evt;     // Index 0 overflow, index 1 underflow.
    logic [1:0]       err_sticky;
    logic [1:0][15:0] err_cnt;

    // Address and data are taken together, one write in flight.
    assign wr_take = axil_req.awvalid && axil_req.wvalid && !bvalid_q;
    assign rd_take = axil_req.arvalid && !rvalid_q;

    always_comb begin
        case (axil_req.awaddr)
            reg_status, reg_wr_count, reg_rd_count, reg_oflow_cnt,
            reg_uflow_cnt, reg_depth, reg_control: wr_mapped = 1'b1;
            default:                                wr_mapped = 1'b0;
        endcase
    end

    assign ctrl_hit  = wr_take && (axil_req.awaddr == reg_control) && axil_req.wstrb[0];
    assign clear_req = ctrl_hit && axil_req.wdata[ctrl_clear_bit];

    always_comb begin
        rd_resp = resp_okay;
        case (axil_req.araddr)
            reg_status:    rd_word = {28'd0, err_sticky[1], err_sticky[0],
                                      status.empty, status.full};
            reg_wr_count:  rd_word = 32'(wr_count);
            reg_rd_count:  rd_word = 32'(rd_count);
            reg_oflow_cnt: rd_word = {16'd0, err_cnt[0]};
            reg_uflow_cnt: rd_word = {16'd0, err_cnt[1]};
            reg_depth:     rd_word = 32'(DEPTH);
            reg_control:   rd_word = '0; // Write only.
            default: begin
                rd_word = '0;
                rd_resp = resp_slverr;
            end
        endcase
    end

    always_ff @(posedge rd_clk) begin
        if (rd_srst) begin
            bvalid_q <= 1'b0;
            rvalid_q <= 1'b0;
            flush_q  <= 1'b0;
        end else begin
            if (wr_take) begin
                bvalid_q <= 1'b1;
            end else if (axil_req.bready) begin
                bvalid_q <= 1'b0;
            end
            if (rd_take) begin
                rvalid_q <= 1'b1;
            end else if (axil_req.rready) begin
                rvalid_q <= 1'b0;
            end
            flush_q <= ctrl_hit && axil_req.wdata[ctrl_flush_bit]; // Core flushes next edge.
        end
    end

    always_ff @(posedge rd_clk) begin
        if (wr_take) begin
            bresp_q <= wr_mapped ? resp_okay : resp_slverr;
        end
        if (rd_take) begin
            rdata_q <= rd_word;
            rresp_q <= rd_resp;
        end
    end

    assign err_evt = {status.uflow, status.oflow};

    // Sticky flags and saturating counters. An event on the clear edge still counts.
    always_ff @(posedge rd_clk) begin
        if (rd_srst) begin
            err_sticky <= '0;
            err_cnt    <= '0;
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (clear_req) begin
                    err_sticky[i] <= err_evt[i];
                    err_cnt[i]    <= 16'(err_evt[i]);
                end else if (err_evt[i]) begin
                    err_sticky[i] <= 1'b1;
                    if (err_cnt[i] != '1) begin
                        err_cnt[i] <= err_cnt[i] + 1'b1;
                    end
                end
            end
        end
    end

    assign flush = flush_q;

    assign axil_rsp.awready = wr_take;
    assign axil_rsp.wready  = wr_take;
    assign axil_rsp.bresp   = bresp_q;
    assign axil_rsp.bvalid  = bvalid_q;
    assign axil_rsp.arready = rd_take;
    assign axil_rsp.rdata   = rdata_q;
    assign axil_rsp.rresp   = rresp_q;
    assign axil_rsp.rvalid  = rvalid_q;

    assert property (@(posedge rd_clk) disable iff (rd_srst)
        bvalid_q && !axil_req.bready |=> bvalid_q && $stable(bresp_q))
        else $error("fifo_axil_regs write response dropped before bready");

    assert property (@(posedge rd_clk) disable iff (rd_srst)
        rvalid_q && !axil_req.rready |=> rvalid_q && $stable(rdata_q) && $stable(rresp_q))
        else $error("fifo_axil_regs read response changed before rready");

endmodule

// ==== fifo_axil_tb.sv ====
module fifo_axil_tb import axil_pkg::*, fifo_pkg::*; ();

    localparam int DEPTH    = 16;
    localparam int CNT_WID  = $clog2(DEPTH + 2); // Count width with the FWFT output stage.
    localparam int BUS_LEN  = 16;                // Cycle budget for one register access.
    localparam int BUS_WAIT = 10;
    localparam int TEST_CYCLES = 3 + (4 + 2 * BUS_LEN) + (2 * DEPTH + 4)
        + (2 * DEPTH + 8 + 6 * BUS_LEN) + (8 + 3 * BUS_LEN) + 4 * BUS_LEN + (200 + DEPTH + 4);

    logic               rd_clk;
    logic               rd_srst;
    logic               wr_rdy;
    logic               wr;
    data_t              wr_data;
    logic               rd;
    logic               rd_ack;
    data_t              rd_data;
    logic [CNT_WID-1:0] wr_count;
    logic [CNT_WID-1:0] rd_count;
    logic               full;
    logic               empty;
    logic               oflow;
    logic               uflow;
    axil_req_t          axil_req;
    axil_rsp_t          axil_rsp;

    data_t              model_q [$]; // Words the FIFO should hold, head first.
    int                 prev_size;   // Model size one edge back, for the lagged rd_count.
    logic               pend_oflow;
    logic               pend_uflow;
    int                 seed = 44;

    fifo_axil fifo_axil_inst (
        .rd_clk   (rd_clk),
        .rd_srst  (rd_srst),
        .wr_rdy   (wr_rdy),
        .wr       (wr),
        .wr_data  (wr_data),
        .rd       (rd),
        .rd_ack   (rd_ack),
        .rd_data  (rd_data),
        .wr_count (wr_count),
        .rd_count (rd_count),
        .full     (full),
        .empty    (empty),
        .oflow    (oflow),
        .uflow    (uflow),
        .axil_req (axil_req),
        .axil_rsp (axil_rsp)
    );

    initial begin
        rd_clk = 1'b0;
        forever #20 rd_clk = ~rd_clk;
    end

    initial begin
        #(TEST_CYCLES * 40 * 2);
        fail_run("Watchdog expired before the tests finished");
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_data(input string name, input data_t exp, input data_t act);
        if (exp !== act)
            fail_run($sformatf("** Error: %s expected 0x%h actual 0x%h", name, exp, act));
    endtask

    task automatic check_status(input string name, input fifo_status_t exp,
                                input fifo_status_t act);
        if (exp !== act)
            fail_run($sformatf("** Error: %s expected 0x%h actual 0x%h", name, exp, act));
    endtask

    task automatic check_count(input string name, input logic [CNT_WID-1:0] exp,
                               input logic [CNT_WID-1:0] act);
        if (exp !== act)
            fail_run($sformatf("** Error: %s expected 0x%h actual 0x%h", name, exp, act));
    endtask

    task automatic check_word(input string name, input axil_data_t exp, input axil_data_t act);
        if (exp !== act)
            fail_run($sformatf("** Error: %s expected 0x%h actual 0x%h", name, exp, act));
    endtask

    task automatic check_resp(input string name, input axil_resp_t exp, input axil_resp_t act);
        if (exp !== act)
            fail_run($sformatf("** Error: %s expected 0x%h actual 0x%h", name, exp, act));
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act)
            fail_run($sformatf("** Error: %s expected 0x%h actual 0x%h", name, exp, act));
    endtask

    task automatic settle_model();
        prev_size  = model_q.size();
        pend_oflow = 1'b0;
        pend_uflow = 1'b0;
    endtask

    // One clock of FIFO traffic, checked against the model at the falling edge.
    task automatic run_cycle(input logic w, input data_t d, input logic r);
        fifo_status_t exp_st;
        fifo_status_t act_st;
        logic         take_wr;
        logic         take_rd;
        @(posedge rd_clk);
        wr      <= w;
        wr_data <= d;
        rd      <= r;
        @(negedge rd_clk);
        exp_st.full  = (model_q.size() == DEPTH);
        exp_st.empty = (model_q.size() == 0);
        exp_st.oflow = pend_oflow; // Pulse from the previous edge.
        exp_st.uflow = pend_uflow;
        act_st = {full, empty, oflow, uflow};
        check_status("status", exp_st, act_st);
        check_bit("wr_rdy", !exp_st.full, wr_rdy);
        check_count("wr_count", CNT_WID'(model_q.size()), wr_count);
        check_count("rd_count", CNT_WID'(prev_size), rd_count);
        take_rd = r && !exp_st.empty;
        take_wr = w && !exp_st.full;
        check_bit("rd_ack", take_rd, rd_ack);
        if (take_rd)
            check_data("rd_data", model_q[0], rd_data);
        pend_oflow = w && exp_st.full;
        pend_uflow = r && exp_st.empty;
        prev_size  = model_q.size();
        if (take_rd)
            void'(model_q.pop_front());
        if (take_wr)
            model_q.push_back(d);
    endtask

    task automatic axil_read(input axil_addr_t addr, input int hold,
                             output axil_data_t data, output axil_resp_t resp);
        int n;
        @(posedge rd_clk);
        axil_req.araddr  <= addr;
        axil_req.arvalid <= 1'b1;
        n = 0;
        do begin
            @(negedge rd_clk);
            n++;
            if (n > BUS_WAIT)
                fail_run("Read address was never accepted");
        end while (!axil_rsp.arready);
        @(posedge rd_clk);
        axil_req.arvalid <= 1'b0;
        n = 0;
        do begin
            @(negedge rd_clk);
            n++;
            if (n > BUS_WAIT)
                fail_run("Read response never arrived");
        end while (!axil_rsp.rvalid);
        data = axil_rsp.rdata;
        resp = axil_rsp.rresp;
        repeat (hold) begin // Host stalls with rready low.
            @(negedge rd_clk);
            if (!axil_rsp.rvalid)
                fail_run("rvalid dropped before rready was given");
            check_word("rdata", data, axil_rsp.rdata);
            check_resp("rresp", resp, axil_rsp.rresp);
        end
        @(posedge rd_clk);
        axil_req.rready <= 1'b1;
        @(posedge rd_clk);
        axil_req.rready <= 1'b0;
        settle_model();
    endtask

    task automatic axil_write(input axil_addr_t addr, input axil_data_t data, input int hold,
                              output axil_resp_t resp);
        int n;
        @(posedge rd_clk);
        axil_req.awaddr  <= addr;
        axil_req.awvalid <= 1'b1;
        axil_req.wdata   <= data;
        axil_req.wstrb   <= 4'hF;
        axil_req.wvalid  <= 1'b1;
        n = 0;
        do begin
            @(negedge rd_clk);
            n++;
            if (n > BUS_WAIT)
                fail_run("Write address and data were never accepted");
        end while (!axil_rsp.awready);
        check_bit("wready", 1'b1, axil_rsp.wready);
        @(posedge rd_clk);
        axil_req.awvalid <= 1'b0;
        axil_req.wvalid  <= 1'b0;
        n = 0;
        do begin
            @(negedge rd_clk);
            n++;
            if (n > BUS_WAIT)
                fail_run("Write response never arrived");
        end while (!axil_rsp.bvalid);
        resp = axil_rsp.bresp;
        repeat (hold) begin
            @(negedge rd_clk);
            if (!axil_rsp.bvalid)
                fail_run("bvalid dropped before bready was given");
        end
        @(posedge rd_clk);
        axil_req.bready <= 1'b1;
        @(posedge rd_clk);
        axil_req.bready <= 1'b0;
        settle_model();
    endtask

    task automatic read_expect(input axil_addr_t addr, input axil_data_t exp_data,
                               input axil_resp_t exp_resp);
        axil_data_t data;
        axil_resp_t resp;
        axil_read(addr, 0, data, resp);
        check_resp("rresp", exp_resp, resp);
        check_word("rdata", exp_data, data);
    endtask

    task automatic write_expect(input axil_addr_t addr, input axil_data_t data, input int hold,
                                input axil_resp_t exp_resp);
        axil_resp_t resp;
        axil_write(addr, data, hold, resp);
        check_resp("bresp", exp_resp, resp);
    endtask

    // Follows a flush write and checks the cycle in which the FIFO empties.
    task automatic watch_flush();
        do begin
            @(negedge rd_clk);
        end while (!axil_rsp.awready);
        @(negedge rd_clk);
        check_bit("empty", 1'b0, empty); // Flush pulse not at the core yet.
        check_count("wr_count", CNT_WID'(model_q.size()), wr_count);
        @(negedge rd_clk);
        check_bit("empty", 1'b1, empty);
        check_count("wr_count", '0, wr_count);
    endtask

    task automatic fill(input int n);
        repeat (n) run_cycle(1'b1, data_t'($random(seed)), 1'b0);
        run_cycle(1'b0, '0, 1'b0);
    endtask

    task automatic drain();
        while (model_q.size() > 0)
            run_cycle(1'b0, '0, 1'b1);
        run_cycle(1'b0, '0, 1'b0);
    endtask

    task automatic test_reset();
        run_cycle(1'b0, '0, 1'b0);
        check_bit("awready", 1'b0, axil_rsp.awready);
        check_bit("wready", 1'b0, axil_rsp.wready);
        check_bit("bvalid", 1'b0, axil_rsp.bvalid);
        check_bit("arready", 1'b0, axil_rsp.arready);
        check_bit("rvalid", 1'b0, axil_rsp.rvalid);
        read_expect(reg_status, 32'h2, resp_okay);
        read_expect(reg_depth, 32'(DEPTH), resp_okay);
    endtask

    task automatic test_fill_drain();
        fill(DEPTH);
        check_bit("full", 1'b1, full);
        check_bit("wr_rdy", 1'b0, wr_rdy);
        check_count("wr_count", CNT_WID'(DEPTH), wr_count);
        drain();
        check_bit("empty", 1'b1, empty);
    endtask

    task automatic test_errors();
        fill(DEPTH);
        repeat (2) run_cycle(1'b1, data_t'($random(seed)), 1'b0); // Dropped words.
        run_cycle(1'b0, '0, 1'b0);
        drain();
        repeat (3) run_cycle(1'b0, '0, 1'b1);
        run_cycle(1'b0, '0, 1'b0);
        read_expect(reg_status, 32'hE, resp_okay);
        read_expect(reg_oflow_cnt, 32'd2, resp_okay);
        read_expect(reg_uflow_cnt, 32'd3, resp_okay);
        write_expect(reg_control, 32'h1, 0, resp_okay);
        read_expect(reg_status, 32'h2, resp_okay);
        read_expect(reg_oflow_cnt, 32'd0, resp_okay);
        read_expect(reg_uflow_cnt, 32'd0, resp_okay);
    endtask

    task automatic test_flush();
        fill(5);
        fork
            write_expect(reg_control, 32'h2, 0, resp_okay);
            watch_flush();
        join
        model_q.delete();
        settle_model();
        run_cycle(1'b0, '0, 1'b0);
        read_expect(reg_wr_count, 32'd0, resp_okay);
        read_expect(reg_rd_count, 32'd0, resp_okay);
    endtask

    task automatic test_bus();
        axil_data_t data;
        axil_resp_t resp;
        read_expect(8'h40, 32'd0, resp_slverr);
        axil_read(reg_depth, 5, data, resp);
        check_resp("rresp", resp_okay, resp);
        check_word("rdata", 32'(DEPTH), data);
        write_expect(reg_status, 32'h0, 4, resp_okay);
        write_expect(8'h44, 32'h0, 0, resp_slverr);
    endtask

    task automatic test_mix();
        logic [31:0] rnd;
        repeat (200) begin
            rnd = $random(seed);
            run_cycle(rnd[0], rnd[31:16], rnd[1]);
        end
        drain();
    endtask

    initial begin
        rd_srst  = 1'b1;
        wr       = 1'b0;
        wr_data  = '0;
        rd       = 1'b0;
        axil_req = '0;
        settle_model();
        repeat (3) @(posedge rd_clk);
        rd_srst <= 1'b0;
        test_reset();
        test_fill_drain();
        test_errors();
        test_flush();
        test_bus();
        test_mix();
        $display("STATUS: PASS");
        $finish;
    end

endmodule

// ==== fifo_core.sv ====
module fifo_core import fifo_pkg::*; #(
    parameter int  DEPTH      = 16,
    parameter bit  FWFT       = 1,
    parameter bit  OFLOW_PROT = 1,
    parameter bit  UFLOW_PROT = 1,
    localparam int CNT_WID    = FWFT ? $clog2(DEPTH + 2) : $clog2(DEPTH + 1)
) (
    input  logic               rd_clk,
    input  logic               rd_srst,

    output logic               wr_rdy,
    input  logic               wr,
    input  data_t              wr_data,

    input  logic               rd,
    input  logic               flush,
    output logic               rd_ack,
    output data_t              rd_data,

    output logic [CNT_WID-1:0] wr_count,
    output logic [CNT_WID-1:0] rd_count,
    output fifo_status_t       status
);

    localparam int AW = $clog2(DEPTH);

    data_t              mem [DEPTH];
    logic [AW-1:0]      wr_ptr;
    logic [AW-1:0]      rd_ptr;
    logic [CNT_WID-1:0] count;       // Includes the FWFT output word.
    logic               full;
    logic               empty;
    logic               wr_go;
    logic               rd_go;
    logic               rd_ok;
    logic               head_valid;
    logic               head_free;
    logic               mem_empty;
    logic               bypass;
    logic               mem_wr;
    logic               mem_rd;
    logic               rd_ptr_inc;
    logic               rd_ack_q;
    data_t              out_data;    // FWFT head word or registered read data.
    logic               oflow_q;
    logic               uflow_q;

    assign full  = (count == CNT_WID'(DEPTH));
    assign empty = (count == '0);

    assign wr_rdy = !full;

    // Without protection the pointers run on regardless.
    assign wr_go = wr && (!full || !OFLOW_PROT);
    assign rd_ok = rd && !empty;
    assign rd_go = rd && (!empty || !UFLOW_PROT);

    always_comb begin
        if (FWFT) begin
            head_free = !head_valid || rd_ok;             // Head slot can take a word.
            mem_empty = (count == CNT_WID'(head_valid));  // Nothing queued behind the head.
            bypass    = wr_go && mem_empty && head_free;  // Straight into the output stage.
            mem_rd    = head_free && !mem_empty;          // Prefetch next word.
        end else begin
            head_free = 1'b0;
            mem_empty = empty;
            bypass    = 1'b0;
            mem_rd    = rd_ok;
        end
        mem_wr     = wr_go && !bypass;
        rd_ptr_inc = mem_rd || (rd_go && empty); // Unprotected underflow slips the pointer.
    end

    always_ff @(posedge rd_clk) begin
        if (rd_srst || flush) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            head_valid <= 1'b0;
            rd_ack_q   <= 1'b0;
        end else begin
            if (mem_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_ptr_inc) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + CNT_WID'(wr_go) - CNT_WID'(rd_go);
            if (bypass || mem_rd) begin
                head_valid <= 1'b1;
            end else if (rd_ok) begin
                head_valid <= 1'b0;
            end
            rd_ack_q <= rd_ok;
        end
    end

    always_ff @(posedge rd_clk) begin
        if (mem_wr) begin
            mem[wr_ptr] <= wr_data;
        end
        if (bypass) begin
            out_data <= wr_data;
        end else if (mem_rd) begin
            out_data <= mem[rd_ptr];
        end
    end

    // Error pulses, one cycle after the offending strobe.
    always_ff @(posedge rd_clk) begin
        if (rd_srst) begin
            oflow_q <= 1'b0;
            uflow_q <= 1'b0;
        end else begin
            oflow_q <= wr && full;
            uflow_q <= rd && empty;
        end
    end

    assign rd_ack  = FWFT ? rd_ok : rd_ack_q;
    assign rd_data = out_data;

    assign wr_count = count;
    assign rd_count = count;

    assign status.full  = full;
    assign status.empty = empty;
    assign status.oflow = oflow_q;
    assign status.uflow = uflow_q;

    // Occupancy stays within the storage, output stage included.
    assert property (@(posedge rd_clk) disable iff (rd_srst || !OFLOW_PROT || !UFLOW_PROT)
        count <= CNT_WID'(DEPTH))
        else $error("fifo_core count above DEPTH");

    assert property (@(posedge rd_clk) disable iff (rd_srst || !OFLOW_PROT)
        full && !flush |=> $stable(wr_ptr))
        else $error("fifo_core write pointer moved while full");

    assert property (@(posedge rd_clk) disable iff (rd_srst || !UFLOW_PROT)
        empty && !flush |=> $stable(rd_ptr))
        else $error("fifo_core read pointer moved while empty");

endmodule

// ==== fifo_pkg.sv ====
package fifo_pkg;

    // One FIFO entry.
    typedef logic [15:0] data_t;

    // Status handed from the core to the register block.
    // The oflow and uflow fields are single cycle event pulses,
    // full and empty are levels.
    typedef struct packed {
        logic full;
        logic empty;
        logic oflow; // Write seen while full.
        logic uflow; // Read seen while empty.
    } fifo_status_t;

endpackage

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the fifo_axil testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=fifo_axil_sim

verilator --binary --timing --assert -Wno-fatal \
    -f fifo_axil.f --top-module fifo_axil_tb \
    --Mdir obj_dir -o "$BIN"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "STATUS: FAIL" "$LOG"; then
    echo "Simulation reported failure"
    exit 1
fi

if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

echo "Simulation finished without failure"
exit 0
